// File: bench/tb_uart_loader.sv
`timescale 1ns/1ps
`default_nettype none

module tb_uart_loader;

    // Bytes sent over all tests, counting headers and checksums.
    localparam int TOTAL_BYTES = 24 + 16 + (10 + 9 + 16) + (4 + 4) + 4 + (1 + 56 + 24);
    localparam longint WATCHDOG_NS = longint'(TOTAL_BYTES) * 10 *
                                     uart_line_pkg::CLKS_PER_BIT * 20 * 2;
    localparam int RESULT_WAIT = 4 * uart_line_pkg::CLKS_PER_BIT + 300;

    logic                           clk;
    logic                           rstn;
    logic                           rx;
    logic                           start;
    logic                           prog_en;
    uart_line_pkg::word_t           prog_addr;
    uart_line_pkg::word_t           prog_data;
    loader_proto_pkg::res_t         res;

    uart_line_pkg::byte_t           tx_data[$];     // Data bytes of the frame being built.
    uart_line_pkg::word_t           exp_addr_q[$];
    uart_line_pkg::word_t           exp_data_q[$];
    loader_proto_pkg::res_t         exp_res_q[$];
    loader_proto_pkg::res_t         res_q[$];
    logic                           exp_start = 1'b0;
    integer                         seed = 32'hc019;
    int                             error_count = 0;
    int                             check_count = 0;
    int                             test_count = 0;
    int                             errors_before = 0;

    uart_loader_top UUT (
        .clk       (clk),
        .rstn      (rstn),
        .rx        (rx),
        .start     (start),
        .prog_en   (prog_en),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .res       (res)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before all tests finished");
        $display("Result: FAILED");
        $finish;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    // ====================================================================
    // Reference model
    // ====================================================================
    function automatic loader_proto_pkg::res_t expect_frame(input uart_line_pkg::byte_t cmd,
            input uart_line_pkg::byte_t len, input uart_line_pkg::word_t addr,
            input bit corrupt);
        int nwords;
        if (len != 0 && (len < 8 || len[1:0] != 2'b00)) return loader_proto_pkg::RES_NAK;
        if (corrupt) return loader_proto_pkg::RES_NAK;
        case (cmd)
            loader_proto_pkg::CMD_RESET: begin
                exp_start = 1'b0;
                return loader_proto_pkg::RES_ACK;
            end
            loader_proto_pkg::CMD_RUN: begin
                exp_start = 1'b1;
                return loader_proto_pkg::RES_ACK;
            end
            loader_proto_pkg::CMD_WRITE: begin
                if (len == 0) return loader_proto_pkg::RES_NAK;   // Nothing to write.
                nwords = (int'(len) - 4) / 4;
                for (int i = 0; i < nwords; i++) begin
                    exp_addr_q.push_back(addr + 4 * i);
                    exp_data_q.push_back({tx_data[4*i+3], tx_data[4*i+2],
                                          tx_data[4*i+1], tx_data[4*i]});
                end
                return loader_proto_pkg::RES_ACK;
            end
            default: return loader_proto_pkg::RES_NAK;
        endcase
    endfunction

    // ====================================================================
    // Serial driver
    // ====================================================================
    task automatic send_byte(input uart_line_pkg::byte_t b, input bit bad_stop);
        logic [9:0] line_bits;
        line_bits = {~bad_stop, b, 1'b0};   // Stop, data LSB first, start.
        for (int i = 0; i < 10 + bad_stop; i++) begin
            @(posedge clk);
            #1;
            rx = (i < 10) ? line_bits[i] : 1'b1;
            repeat (uart_line_pkg::CLKS_PER_BIT - 1) @(posedge clk);
        end
    endtask

    task automatic send_frame(input uart_line_pkg::byte_t cmd, input uart_line_pkg::byte_t len,
                              input uart_line_pkg::word_t addr, input bit corrupt);
        uart_line_pkg::byte_t frame_bytes[$];
        uart_line_pkg::byte_t csum;
        frame_bytes = '{loader_proto_pkg::START_FLAG, cmd, len};
        if (len != 0) begin
            for (int i = 0; i < 4; i++) frame_bytes.push_back(addr[8*i +: 8]);
            for (int i = 0; i < int'(len) - 4; i++) frame_bytes.push_back(tx_data[i]);
        end
        csum = '0;
        foreach (frame_bytes[i]) csum += frame_bytes[i];
        if (corrupt) csum = csum + 8'h01;
        frame_bytes.push_back(csum);
        foreach (frame_bytes[i]) send_byte(frame_bytes[i], 1'b0);
    endtask

    task automatic run_frame(input uart_line_pkg::byte_t cmd, input uart_line_pkg::byte_t len,
                             input uart_line_pkg::word_t addr, input bit corrupt);
        exp_res_q.push_back(expect_frame(cmd, len, addr, corrupt));
        send_frame(cmd, len, addr, corrupt);
    endtask

    task automatic fill_random(input int n);
        tx_data.delete();
        repeat (n) tx_data.push_back(uart_line_pkg::byte_t'($random(seed)));
    endtask

    task automatic collect_results();
        int cycles;
        cycles = 0;
        while (res_q.size() < exp_res_q.size() && cycles < RESULT_WAIT) begin
            @(posedge clk);
            cycles++;
        end
        if (res_q.size() < exp_res_q.size()) begin
            error_count++;
            $display("Timed out waiting for %0d result code(s)", exp_res_q.size() - res_q.size());
        end
        while (res_q.size() > 0 && exp_res_q.size() > 0) begin
            check_value("res", res_q.pop_front(), exp_res_q.pop_front());
        end
        repeat (2 * uart_line_pkg::CLKS_PER_BIT) @(posedge clk);
        check_value("extra res pulses", res_q.size(), 0);
        check_value("missing writes", exp_addr_q.size(), 0);
        check_value("start", start, exp_start);
        res_q.delete();
        exp_res_q.delete();
        exp_addr_q.delete();
        exp_data_q.delete();
    endtask

    task automatic end_test(input string name);
        test_count++;
        $display("Test %0d %s: %0d error(s)", test_count, name, error_count - errors_before);
        errors_before = error_count;
    endtask

    // Outputs are sampled on the falling edge, half a period after they settle.
    always @(negedge clk) begin
        if (rstn && res !== loader_proto_pkg::RES_STBY) res_q.push_back(res);
    end

    always @(negedge clk) begin
        if (rstn && prog_en === 1'b1) begin
            if (exp_addr_q.size() == 0) begin
                error_count++;
                $display("Unexpected program write at address 0x%h", prog_addr);
            end else begin
                check_value("prog_addr", prog_addr, exp_addr_q.pop_front());
                check_value("prog_data", prog_data, exp_data_q.pop_front());
            end
        end
    end

    initial begin
        rstn = 1'b0;
        rx   = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        rstn = 1'b1;
        repeat (4) @(posedge clk);

        fill_random(16);
        run_frame(loader_proto_pkg::CMD_WRITE, 8'd20, uart_line_pkg::word_t'($random(seed)), 0);
        collect_results();
        end_test("write burst");

        fill_random(8);
        run_frame(loader_proto_pkg::CMD_WRITE, 8'd12, 32'h0000_2000, 1);
        collect_results();
        end_test("bad checksum");

        tx_data = '{8'h11, 8'h22};          // No byte here looks like a start flag.
        run_frame(loader_proto_pkg::CMD_WRITE, 8'd6, 32'h0000_0100, 0);
        collect_results();
        run_frame(loader_proto_pkg::CMD_WRITE, 8'd5, 32'h0000_0100, 0);
        collect_results();
        fill_random(8);
        run_frame(loader_proto_pkg::CMD_WRITE, 8'd12, 32'h0000_3000, 0);
        collect_results();
        end_test("bad length");

        run_frame(loader_proto_pkg::CMD_RUN, 8'd0, '0, 0);
        collect_results();
        run_frame(loader_proto_pkg::CMD_RESET, 8'd0, '0, 0);
        collect_results();
        end_test("run and reset");

        run_frame(8'h3C, 8'd0, '0, 0);
        collect_results();
        end_test("unknown command");

        send_byte(loader_proto_pkg::START_FLAG, 1'b1);
        fill_random(48);
        run_frame(loader_proto_pkg::CMD_WRITE, 8'd52, 32'h0001_0000, 0);
        fill_random(16);
        run_frame(loader_proto_pkg::CMD_WRITE, 8'd20, 32'h0002_0040, 0);
        collect_results();
        end_test("framing error and back-to-back");

        $display("Tests: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/frame_loader.sv
`timescale 1ns/1ps
`default_nettype none

module frame_loader (
    input  wire logic                   clk,
    input  wire logic                   rstn,
    input  wire uart_line_pkg::byte_t   fifo_data,
    input  wire logic                   fifo_valid,
    input  wire logic                   fifo_empty,
    output logic                        pop,
    output logic                        start,
    output logic                        prog_en,
    output uart_line_pkg::word_t        prog_addr,
    output uart_line_pkg::word_t        prog_data,
    output loader_proto_pkg::res_t      res
);

    loader_proto_pkg::loader_state_t    state;
    loader_proto_pkg::cmd_t             cmd;
    uart_line_pkg::word_t               base_addr;
    uart_line_pkg::byte_t               csum;
    uart_line_pkg::byte_t               data_len;   // Data bytes behind the address.
    uart_line_pkg::byte_t               data_cnt;
    uart_line_pkg::byte_t               wr_off;     // Byte offset of the next word.
    logic [2:0]                         addr_cnt;
    uart_line_pkg::byte_t               data_buf [0:loader_proto_pkg::MAX_PAYLOAD-1];
    uart_line_pkg::word_t               cur_word;
    uart_line_pkg::word_t               cur_addr;
    logic                               buf_we;
    logic                               csum_ok;
    logic                               write_word;
    logic                               last_word;

    // ====================================================================
    // FIFO read side and payload buffer
    // ====================================================================
    // One byte in flight at a time; nothing is read during a write burst.
    assign pop = !fifo_empty && !fifo_valid && (state != loader_proto_pkg::BUSY);

    assign buf_we = fifo_valid && (state == loader_proto_pkg::PAYLOAD) &&
                    (addr_cnt == loader_proto_pkg::ADDR_BYTES);

    always_ff @(posedge clk) begin
        if (buf_we) begin
            data_buf[data_cnt] <= fifo_data;
        end
    end

    assign cur_word = {data_buf[wr_off + 8'd3], data_buf[wr_off + 8'd2],
                       data_buf[wr_off + 8'd1], data_buf[wr_off]};
    assign cur_addr = base_addr + uart_line_pkg::word_t'(wr_off);

    // A write burst starts straight from a good checksum.
    assign csum_ok    = fifo_valid && (fifo_data == csum);
    assign write_word = ((state == loader_proto_pkg::CHECKSUM) && csum_ok &&
                         (cmd == loader_proto_pkg::CMD_WRITE) && (data_len != '0)) ||
                        ((state == loader_proto_pkg::BUSY) && (wr_off != data_len));
    assign last_word  = write_word && (wr_off + 8'd4 == data_len);

    always_ff @(posedge clk) begin
        if (write_word) begin
            prog_addr <= cur_addr;
            prog_data <= cur_word;
        end
    end

    // ====================================================================
    // Frame FSM
    // ====================================================================
    always_ff @(posedge clk) begin
        if (!rstn) begin
            state    <= loader_proto_pkg::IDLE;
            cmd      <= loader_proto_pkg::CMD_RESET;
            res      <= loader_proto_pkg::RES_STBY;
            start    <= 1'b0;
            prog_en  <= 1'b0;
            csum     <= '0;
            data_len <= '0;
            data_cnt <= '0;
            wr_off   <= '0;
            addr_cnt <= '0;
        end else begin
            res     <= last_word ? loader_proto_pkg::RES_ACK : loader_proto_pkg::RES_STBY;
            prog_en <= write_word;
            if (write_word) wr_off <= wr_off + 8'd4;
            if (fifo_valid) csum <= csum + fifo_data;

            case (state)
                loader_proto_pkg::IDLE: begin
                    if (fifo_valid && fifo_data == loader_proto_pkg::START_FLAG) begin
                        csum  <= loader_proto_pkg::START_FLAG;
                        state <= loader_proto_pkg::CMD;
                    end
                end
                loader_proto_pkg::CMD: if (fifo_valid) begin
                    cmd   <= loader_proto_pkg::cmd_t'(fifo_data);
                    state <= loader_proto_pkg::LEN;
                end
                loader_proto_pkg::LEN: if (fifo_valid) begin
                    addr_cnt <= '0;
                    data_cnt <= '0;
                    wr_off   <= '0;
                    if (fifo_data == '0) begin
                        data_len <= '0;
                        state    <= loader_proto_pkg::CHECKSUM;
                    end else if (fifo_data >= loader_proto_pkg::MIN_LEN &&
                                 fifo_data[1:0] == 2'b00) begin
                        data_len <= fifo_data -
                                    uart_line_pkg::byte_t'(loader_proto_pkg::ADDR_BYTES);
                        state    <= loader_proto_pkg::PAYLOAD;
                    end else begin
                        res   <= loader_proto_pkg::RES_NAK;
                        state <= loader_proto_pkg::IDLE;
                    end
                end
                loader_proto_pkg::PAYLOAD: if (fifo_valid) begin
                    if (addr_cnt != loader_proto_pkg::ADDR_BYTES) begin
                        base_addr[addr_cnt[1:0]*8 +: 8] <= fifo_data;
                        addr_cnt                        <= addr_cnt + 1'b1;
                    end else begin
                        data_cnt <= data_cnt + 1'b1;
                        if (data_cnt == data_len - 8'd1) begin
                            state <= loader_proto_pkg::CHECKSUM;
                        end
                    end
                end
                loader_proto_pkg::CHECKSUM: if (fifo_valid) begin
                    state <= loader_proto_pkg::IDLE;
                    if (!csum_ok) begin
                        res <= loader_proto_pkg::RES_NAK;
                    end else begin
                        case (cmd)
                            loader_proto_pkg::CMD_RESET: begin
                                start <= 1'b0;
                                res   <= loader_proto_pkg::RES_ACK;
                            end
                            loader_proto_pkg::CMD_RUN: begin
                                start <= 1'b1;
                                res   <= loader_proto_pkg::RES_ACK;
                            end
                            loader_proto_pkg::CMD_WRITE: begin
                                // An empty write has nothing to store and is refused.
                                if (data_len == '0) res <= loader_proto_pkg::RES_NAK;
                                else state <= loader_proto_pkg::BUSY;
                            end
                            default: res <= loader_proto_pkg::RES_NAK;
                        endcase
                    end
                end
                loader_proto_pkg::BUSY: begin
                    if (wr_off == data_len) begin
                        state <= loader_proto_pkg::IDLE;   // Last word is on the bus now.
                    end
                end
                default: state <= loader_proto_pkg::IDLE;
            endcase
        end
    end

    a_prog_in_busy: assert property (@(posedge clk) disable iff (!rstn)
        prog_en |-> state == loader_proto_pkg::BUSY)
        else $error("prog_en high outside BUSY");

endmodule

`default_nettype wire

// File: hdl/loader_proto_pkg.sv
`default_nettype none

package loader_proto_pkg;

    // ====================================================================
    // Frame layout
    // ====================================================================
    localparam logic [7:0] START_FLAG = 8'hA5;

    localparam int ADDR_BYTES  = 4;                 // The address leads the payload with its LSB first.
    localparam int MIN_LEN     = 8;                 // Smallest payload that carries a word.
    localparam int MAX_PAYLOAD = 252;               // Largest length that is a multiple of 4.

    typedef enum logic [7:0] {
        CMD_RESET = 8'd0,
        CMD_RUN   = 8'd1,
        CMD_WRITE = 8'd2
    } cmd_t;

    typedef enum logic [1:0] {
        RES_STBY = 2'd0,
        RES_ACK  = 2'd1,
        RES_NAK  = 2'd2
    } res_t;

    // Loader walks these states once per frame.
    typedef enum logic [2:0] {
        IDLE,
        CMD,
        LEN,
        PAYLOAD,
        CHECKSUM,
        BUSY
    } loader_state_t;

endpackage

`default_nettype wire

// File: hdl/rx_byte_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module rx_byte_fifo (
    input  wire logic                   clk,
    input  wire logic                   rstn,
    input  wire logic                   push,
    input  wire uart_line_pkg::byte_t   wr_data,
    input  wire logic                   pop,
    output uart_line_pkg::byte_t        rd_data,
    output logic                        rd_valid,
    output logic                        empty
);

    uart_line_pkg::byte_t       mem [0:uart_line_pkg::FIFO_DEPTH-1];
    uart_line_pkg::fifo_ptr_t   wr_ptr;
    uart_line_pkg::fifo_ptr_t   rd_ptr;
    uart_line_pkg::fifo_cnt_t   count;
    logic                       full;
    logic                       do_push;
    logic                       do_pop;

    assign empty   = (count == '0);
    assign full    = (count == uart_line_pkg::FIFO_DEPTH);
    assign do_push = push && !full;                 // Bytes pushed into a full FIFO are lost.
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= wr_data;
        end
        if (do_pop) begin
            rd_data <= mem[rd_ptr];
        end
    end

    // Pointers wrap on their own since the depth is a power of two.
    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= do_pop;
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rstn)
        pop |-> !empty)
        else $error("pop while FIFO empty");

endmodule

`default_nettype wire

// File: hdl/uart_line_pkg.sv
`default_nettype none

package uart_line_pkg;

    // ====================================================================
    // Serial line timing
    // ====================================================================
    localparam int CLKS_PER_BIT = 16;               // Oversampling clocks per serial bit.
    localparam int HALF_BIT     = CLKS_PER_BIT / 2;

    typedef logic [$clog2(CLKS_PER_BIT)-1:0] tick_cnt_t;

    // ====================================================================
    // Data widths and FIFO sizing
    // ====================================================================
    typedef logic [7:0]  byte_t;
    typedef logic [31:0] word_t;                    // Program word or address.

    localparam int FIFO_DEPTH = 16;
    typedef logic [3:0] fifo_ptr_t;
    typedef logic [$clog2(FIFO_DEPTH):0] fifo_cnt_t;  // One extra bit so a full FIFO fits.

endpackage

`default_nettype wire

// File: hdl/uart_loader_top.sv
`timescale 1ns/1ps
`default_nettype none

module uart_loader_top (
    input  wire logic                   clk,
    input  wire logic                   rstn,
    input  wire logic                   rx,
    output logic                        start,
    output logic                        prog_en,
    output uart_line_pkg::word_t        prog_addr,
    output uart_line_pkg::word_t        prog_data,
    output loader_proto_pkg::res_t      res
);

    uart_line_pkg::byte_t   byte_data;
    logic                   byte_strobe;
    uart_line_pkg::byte_t   fifo_data;
    logic                   fifo_valid;
    logic                   fifo_empty;
    logic                   pop;

    uart_rx_deser u_rx (
        .clk         (clk),
        .rstn        (rstn),
        .rx          (rx),
        .byte_data   (byte_data),
        .byte_strobe (byte_strobe)
    );

    // Holds bytes while the loader is busy writing words.
    rx_byte_fifo u_fifo (
        .clk      (clk),
        .rstn     (rstn),
        .push     (byte_strobe),
        .wr_data  (byte_data),
        .pop      (pop),
        .rd_data  (fifo_data),
        .rd_valid (fifo_valid),
        .empty    (fifo_empty)
    );

    frame_loader u_loader (
        .clk        (clk),
        .rstn       (rstn),
        .fifo_data  (fifo_data),
        .fifo_valid (fifo_valid),
        .fifo_empty (fifo_empty),
        .pop        (pop),
        .start      (start),
        .prog_en    (prog_en),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data),
        .res        (res)
    );

endmodule

`default_nettype wire

// File: hdl/uart_rx_deser.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx_deser (
    input  wire logic                   clk,
    input  wire logic                   rstn,
    input  wire logic                   rx,
    output uart_line_pkg::byte_t        byte_data,
    output logic                        byte_strobe
);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t                  state;
    logic                       rx_meta;
    logic                       rx_sync;
    logic                       rx_prev;
    uart_line_pkg::tick_cnt_t   tick_cnt;
    logic [2:0]                 bit_idx;
    uart_line_pkg::byte_t       shift_reg;
    logic                       bit_end;

    assign bit_end = (tick_cnt == uart_line_pkg::CLKS_PER_BIT - 1);  // Mid-bit sample point.

    // The idle line is high, so the synchronizer resets to one.
    always_ff @(posedge clk) begin
        if (!rstn) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state       <= RX_IDLE;
            tick_cnt    <= '0;
            bit_idx     <= '0;
            byte_strobe <= 1'b0;
        end else begin
            byte_strobe <= 1'b0;
            case (state)
                RX_IDLE: begin
                    tick_cnt <= '0;
                    if (rx_prev && !rx_sync) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    // Half a bit in, a high line means the edge was a glitch.
                    if (tick_cnt == uart_line_pkg::HALF_BIT - 1) begin
                        tick_cnt <= '0;
                        bit_idx  <= '0;
                        state    <= rx_sync ? RX_IDLE : RX_DATA;
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (bit_end) begin
                        tick_cnt <= '0;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                        bit_idx <= bit_idx + 1'b1;
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (bit_end) begin
                        tick_cnt    <= '0;
                        byte_strobe <= rx_sync;     // A low stop bit drops the byte.
                        state       <= RX_IDLE;
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == RX_DATA && bit_end) begin
            shift_reg <= {rx_sync, shift_reg[7:1]};    // LSB arrives first.
        end
        if (state == RX_STOP && bit_end && rx_sync) begin
            byte_data <= shift_reg;
        end
    end

    a_strobe_single: assert property (@(posedge clk) disable iff (!rstn)
        byte_strobe |=> !byte_strobe)
        else $error("byte_strobe high in two consecutive cycles");

endmodule

`default_nettype wire

// File: project.f
hdl/uart_line_pkg.sv
hdl/loader_proto_pkg.sv
hdl/uart_rx_deser.sv
hdl/rx_byte_fifo.sv
hdl/frame_loader.sv
hdl/uart_loader_top.sv
bench/tb_uart_loader.sv
